// ==== compile.f ====
+incdir+hdl
hdl/floo_pkg.sv
hdl/flit_stream_if.sv
hdl/floo_write_packer.sv
hdl/floo_read_packer.sv
hdl/floo_wormhole_arbiter.sv
hdl/floo_req_chimney.sv
testbench/tb_clock_gen.sv
testbench/floo_req_chimney_asserts.sv
testbench/tb_floo_req_chimney.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := tb_floo_req_chimney
FILELIST   := compile.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing --assert
PASS_MSG   := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/floo_req_vectors.txt ====
# kind axi_id address len base_data dst_id
# kind is W or R, other fields hex, base_data unused for R, dst_id is address bits 11:8
W 1 00000340 00 a0000000 3
R 2 10000a10 00 00000000 a
W 3 20000f04 03 b0000010 f
R 4 00000120 01 00000000 1
W 5 30000580 01 c0000020 5
R 6 40000b00 07 00000000 b
W 7 000007c0 02 d0000030 7
R 8 50000200 00 00000000 2
W 9 60000e40 00 e0000040 e
R a 00000c08 03 00000000 c
W b 70000000 05 f0000050 0
R c 80000d20 00 00000000 d
W d 00000960 01 11110060 9
R e 90000400 02 00000000 4
W f a0000680 00 22220070 6
R 0 b0000f00 00 00000000 f
W 2 c0000110 03 33330080 1
R 3 00000840 01 00000000 8
W 4 d0000ab0 02 44440090 a
R 5 e0000e00 00 00000000 e

// ==== testbench/tb_floo_req_chimney.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench of the request chimney. Reads transactions from the vector
// file, drives AW/W and AR side by side under random flit back-pressure
// and compares every outgoing flit against the expected write/read order.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "floo_consts.svh"

module tb_floo_req_chimney;
  import floo_pkg::*;

  localparam logic [`FLOO_ID_W-1:0] NODE_ID = 4'h5;
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int DRAIN_CYCLES   = 20;

  logic                       clk;
  logic                       rst;
  logic                       aw_valid;
  logic                       aw_ready;
  logic [`FLOO_AXI_ID_W-1:0]  aw_id;
  logic [`FLOO_ADDR_W-1:0]    aw_addr;
  logic [`FLOO_LEN_W-1:0]     aw_len;
  logic                       w_valid;
  logic                       w_ready;
  logic [`FLOO_DATA_W-1:0]    w_data;
  logic                       w_last;
  logic                       ar_valid;
  logic                       ar_ready;
  logic [`FLOO_AXI_ID_W-1:0]  ar_id;
  logic [`FLOO_ADDR_W-1:0]    ar_addr;
  logic [`FLOO_LEN_W-1:0]     ar_len;
  logic                       floo_valid;
  logic                       floo_ready;
  floo_hdr_t                  floo_hdr;
  logic [`FLOO_PAYLOAD_W-1:0] floo_payload;
  int                         seed;

  // Stimulus per transaction kind
  logic [`FLOO_AXI_ID_W-1:0]  wr_id_q[$];
  logic [`FLOO_ADDR_W-1:0]    wr_addr_q[$];
  logic [`FLOO_LEN_W-1:0]     wr_len_q[$];
  logic [`FLOO_DATA_W-1:0]    wr_base_q[$];
  logic [`FLOO_AXI_ID_W-1:0]  rd_id_q[$];
  logic [`FLOO_ADDR_W-1:0]    rd_addr_q[$];
  logic [`FLOO_LEN_W-1:0]     rd_len_q[$];

  // Expected flits, AW and W share one ordered stream
  floo_hdr_t                  exp_wr_hdr_q[$];
  logic [`FLOO_PAYLOAD_W-1:0] exp_wr_payload_q[$];
  floo_hdr_t                  exp_rd_hdr_q[$];
  logic [`FLOO_PAYLOAD_W-1:0] exp_rd_payload_q[$];

  tb_clock_gen #(
    .PERIOD       (20),
    .RESET_CYCLES (4)
  ) u_clock_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  floo_req_chimney u_floo_req_chimney (
    .clk_i          (clk),
    .rst_i          (rst),
    .id_i           (NODE_ID),
    .aw_valid_i     (aw_valid),
    .aw_ready_o     (aw_ready),
    .aw_id_i        (aw_id),
    .aw_addr_i      (aw_addr),
    .aw_len_i       (aw_len),
    .w_valid_i      (w_valid),
    .w_ready_o      (w_ready),
    .w_data_i       (w_data),
    .w_last_i       (w_last),
    .ar_valid_i     (ar_valid),
    .ar_ready_o     (ar_ready),
    .ar_id_i        (ar_id),
    .ar_addr_i      (ar_addr),
    .ar_len_i       (ar_len),
    .floo_valid_o   (floo_valid),
    .floo_ready_i   (floo_ready),
    .floo_hdr_o     (floo_hdr),
    .floo_payload_o (floo_payload)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reporting

  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("error: %s is 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic floo_hdr_t make_hdr(input logic [`FLOO_ID_W-1:0] dst,
                                         input floo_axi_ch_e ch, input logic last);
    floo_hdr_t hdr;
    hdr.dst_id = dst;
    hdr.src_id = NODE_ID;
    hdr.axi_ch = ch;
    hdr.last   = last;
    return hdr;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Vectors

  task automatic load_vectors();
    int                        fd;
    int                        n;
    string                     line;
    logic [7:0]                kind;
    logic [`FLOO_AXI_ID_W-1:0] axi_id;
    logic [`FLOO_ADDR_W-1:0]   addr;
    logic [`FLOO_LEN_W-1:0]    len;
    logic [`FLOO_DATA_W-1:0]   base;
    logic [`FLOO_DATA_W-1:0]   wdata;
    logic [`FLOO_ID_W-1:0]     dst;
    fd = $fopen("testbench/floo_req_vectors.txt", "r");
    if (fd == 0) begin
      stop_on_error("could not open the vector file");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%c %h %h %h %h %h", kind, axi_id, addr, len, base, dst);
      if (n != 6) begin
        stop_on_error($sformatf("malformed vector line: %s", line));
      end
      if (kind == "W") begin
        wr_id_q.push_back(axi_id);
        wr_addr_q.push_back(addr);
        wr_len_q.push_back(len);
        wr_base_q.push_back(base);
        exp_wr_hdr_q.push_back(make_hdr(dst, CH_AW, 1'b1));
        exp_wr_payload_q.push_back({axi_id, addr, len});
        for (int i = 0; i <= int'(len); i++) begin
          wdata = base + i;
          exp_wr_hdr_q.push_back(make_hdr(dst, CH_W, i == int'(len)));
          exp_wr_payload_q.push_back({{(`FLOO_PAYLOAD_W - `FLOO_DATA_W){1'b0}}, wdata});
        end
      end else if (kind == "R") begin
        rd_id_q.push_back(axi_id);
        rd_addr_q.push_back(addr);
        rd_len_q.push_back(len);
        exp_rd_hdr_q.push_back(make_hdr(dst, CH_AR, 1'b1));
        exp_rd_payload_q.push_back({axi_id, addr, len});
      end else begin
        stop_on_error($sformatf("unknown transaction kind in line: %s", line));
      end
    end
    $fclose(fd);
    if (wr_id_q.size() == 0 || rd_id_q.size() == 0) begin
      stop_on_error("vector file holds no writes or no reads");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // AXI drivers

  function automatic logic ready_of(input floo_axi_ch_e ch);
    case (ch)
      CH_AW:   return aw_ready;
      CH_W:    return w_ready;
      default: return ar_ready;
    endcase
  endfunction

  // Called on a rising edge with valid already driven, returns on the
  // edge where the handshake happened
  task automatic wait_accept(input floo_axi_ch_e ch);
    int   waited;
    logic taken;
    waited = 0;
    taken  = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = ready_of(ch);
      @(posedge clk);
      waited++;
      if (!taken && waited > TIMEOUT_CYCLES) begin
        stop_on_error($sformatf("timeout waiting for %s ready", ch.name()));
      end
    end
  endtask

  task automatic drive_writes();
    for (int k = 0; k < wr_id_q.size(); k++) begin
      aw_valid <= 1'b1;
      aw_id    <= wr_id_q[k];
      aw_addr  <= wr_addr_q[k];
      aw_len   <= wr_len_q[k];
      wait_accept(CH_AW);
      aw_valid <= 1'b0;
      for (int i = 0; i <= int'(wr_len_q[k]); i++) begin
        w_valid <= 1'b1;
        w_data  <= wr_base_q[k] + i;
        w_last  <= (i == int'(wr_len_q[k]));
        wait_accept(CH_W);
      end
      w_valid <= 1'b0;
      w_last  <= 1'b0;
    end
  endtask

  task automatic drive_reads();
    for (int k = 0; k < rd_id_q.size(); k++) begin
      ar_valid <= 1'b1;
      ar_id    <= rd_id_q[k];
      ar_addr  <= rd_addr_q[k];
      ar_len   <= rd_len_q[k];
      wait_accept(CH_AR);
    end
    ar_valid <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Flit monitor with random back-pressure

  task automatic take_flit();
    floo_hdr_t                  got_hdr;
    floo_hdr_t                  exp_hdr;
    logic [`FLOO_PAYLOAD_W-1:0] exp_payload;
    got_hdr = floo_hdr;
    if (got_hdr.axi_ch == CH_AR) begin
      if (exp_rd_hdr_q.size() == 0) begin
        stop_on_error("a read flit arrived with no read left to expect");
      end
      exp_hdr     = exp_rd_hdr_q.pop_front();
      exp_payload = exp_rd_payload_q.pop_front();
      check_value("floo_hdr_o (read)", 64'(got_hdr), 64'(exp_hdr));
      check_value("floo_payload_o (read)", 64'(floo_payload), 64'(exp_payload));
    end else begin
      if (exp_wr_hdr_q.size() == 0) begin
        stop_on_error("a write flit arrived with no write left to expect");
      end
      exp_hdr     = exp_wr_hdr_q.pop_front();
      exp_payload = exp_wr_payload_q.pop_front();
      check_value("floo_hdr_o (write)", 64'(got_hdr), 64'(exp_hdr));
      check_value("floo_payload_o (write)", 64'(floo_payload), 64'(exp_payload));
    end
  endtask

  task automatic watch_flits();
    int idle;
    idle = 0;
    while (exp_wr_hdr_q.size() > 0 || exp_rd_hdr_q.size() > 0) begin
      @(posedge clk);
      floo_ready <= (($random(seed) & 3) != 0);
      @(negedge clk);
      if (floo_valid && floo_ready) begin
        take_flit();
        idle = 0;
      end else begin
        idle++;
        if (idle > TIMEOUT_CYCLES) begin
          stop_on_error("timeout waiting for the remaining request flits");
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    int waited;
    seed       = 39;
    aw_valid   = 1'b0;
    aw_id      = '0;
    aw_addr    = '0;
    aw_len     = '0;
    w_valid    = 1'b0;
    w_data     = '0;
    w_last     = 1'b0;
    ar_valid   = 1'b0;
    ar_id      = '0;
    ar_addr    = '0;
    ar_len     = '0;
    floo_ready = 1'b0;
    load_vectors();

    @(negedge clk);
    waited = 0;
    while (rst) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        stop_on_error("reset was never released");
      end
    end

    // Idle state right after reset
    check_value("floo_valid_o", 64'(floo_valid), 64'(0));
    check_value("w_ready_o", 64'(w_ready), 64'(0));
    check_value("aw_ready_o", 64'(aw_ready), 64'(1));
    check_value("ar_ready_o", 64'(ar_ready), 64'(1));

    fork
      begin
        @(posedge clk);
        drive_writes();
      end
      begin
        @(posedge clk);
        drive_reads();
      end
      watch_flits();
    join

    // No flit may show up beyond the expected ones
    @(posedge clk);
    floo_ready <= 1'b1;
    repeat (DRAIN_CYCLES) begin
      @(negedge clk);
      check_value("floo_valid_o", 64'(floo_valid), 64'(0));
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/floo_req_chimney_asserts.sv ====
////////////////////////////////////////////////////////////////////////////
// Handshake checks on the request chimney, bound to its top level.
// Held requests and held flits must stay stable, W only after its AW flit.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "floo_consts.svh"

module floo_req_chimney_asserts (
  input wire logic                       clk_i,
  input wire logic                       rst_i,
  input wire logic                       aw_valid_i,
  input wire logic                       aw_ready_o,
  input wire logic [`FLOO_AXI_ID_W-1:0]  aw_id_i,
  input wire logic [`FLOO_ADDR_W-1:0]    aw_addr_i,
  input wire logic [`FLOO_LEN_W-1:0]     aw_len_i,
  input wire logic                       w_valid_i,
  input wire logic                       w_ready_o,
  input wire logic                       w_last_i,
  input wire logic                       ar_valid_i,
  input wire logic                       ar_ready_o,
  input wire logic [`FLOO_AXI_ID_W-1:0]  ar_id_i,
  input wire logic [`FLOO_ADDR_W-1:0]    ar_addr_i,
  input wire logic [`FLOO_LEN_W-1:0]     ar_len_i,
  input wire logic                       floo_valid_o,
  input wire logic                       floo_ready_i,
  input wire floo_pkg::floo_hdr_t        floo_hdr_o,
  input wire logic [`FLOO_PAYLOAD_W-1:0] floo_payload_o
);
  import floo_pkg::*;

  // Set while an AW flit has left and its burst is not finished
  logic aw_open;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      aw_open <= 1'b0;
    end else if (floo_valid_o && floo_ready_i && (floo_hdr_o.axi_ch == CH_AW)) begin
      aw_open <= 1'b1;
    end else if (w_valid_i && w_ready_o && w_last_i) begin
      aw_open <= 1'b0;
    end
  end

  a_flit_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    floo_valid_o && !floo_ready_i |=>
      floo_valid_o && $stable(floo_hdr_o) && $stable(floo_payload_o))
    else $error("stalled flit changed before its transfer");

  a_aw_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    aw_valid_i && !aw_ready_o |=>
      aw_valid_i && $stable({aw_id_i, aw_addr_i, aw_len_i}))
    else $error("held AW request changed before acceptance");

  a_ar_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    ar_valid_i && !ar_ready_o |=>
      ar_valid_i && $stable({ar_id_i, ar_addr_i, ar_len_i}))
    else $error("held AR request changed before acceptance");

  a_w_after_aw: assert property (@(posedge clk_i) disable iff (rst_i)
    w_ready_o |-> aw_open)
    else $error("W accepted before the AW flit of its burst");

endmodule

bind floo_req_chimney floo_req_chimney_asserts u_asserts (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .aw_valid_i     (aw_valid_i),
  .aw_ready_o     (aw_ready_o),
  .aw_id_i        (aw_id_i),
  .aw_addr_i      (aw_addr_i),
  .aw_len_i       (aw_len_i),
  .w_valid_i      (w_valid_i),
  .w_ready_o      (w_ready_o),
  .w_last_i       (w_last_i),
  .ar_valid_i     (ar_valid_i),
  .ar_ready_o     (ar_ready_o),
  .ar_id_i        (ar_id_i),
  .ar_addr_i      (ar_addr_i),
  .ar_len_i       (ar_len_i),
  .floo_valid_o   (floo_valid_o),
  .floo_ready_i   (floo_ready_i),
  .floo_hdr_o     (floo_hdr_o),
  .floo_payload_o (floo_payload_o)
);

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
////////////////////////////////////////////////////////////////////////////
// Free-running clock and an active-high reset for the testbench.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Reset released on a rising edge after RESET_CYCLES edges
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== hdl/floo_req_chimney.sv ====
////////////////////////////////////////////////////////////////////////////
// Request side of the AXI network interface. Packs AW, W and AR into
// flits and merges them onto one outgoing request link.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "floo_consts.svh"

module floo_req_chimney (
  input  wire logic                      clk_i,
  input  wire logic                      rst_i,
  input  wire logic [`FLOO_ID_W-1:0]     id_i,
  // AW
  input  wire logic                      aw_valid_i,
  output logic                           aw_ready_o,
  input  wire logic [`FLOO_AXI_ID_W-1:0] aw_id_i,
  input  wire logic [`FLOO_ADDR_W-1:0]   aw_addr_i,
  input  wire logic [`FLOO_LEN_W-1:0]    aw_len_i,
  // W
  input  wire logic                      w_valid_i,
  output logic                           w_ready_o,
  input  wire logic [`FLOO_DATA_W-1:0]   w_data_i,
  input  wire logic                      w_last_i,
  // AR
  input  wire logic                      ar_valid_i,
  output logic                           ar_ready_o,
  input  wire logic [`FLOO_AXI_ID_W-1:0] ar_id_i,
  input  wire logic [`FLOO_ADDR_W-1:0]   ar_addr_i,
  input  wire logic [`FLOO_LEN_W-1:0]    ar_len_i,
  // Outgoing request link
  output logic                           floo_valid_o,
  input  wire logic                      floo_ready_i,
  output floo_pkg::floo_hdr_t            floo_hdr_o,
  output logic [`FLOO_PAYLOAD_W-1:0]     floo_payload_o
);

  flit_stream_if wr_flit ();
  flit_stream_if rd_flit ();

  floo_write_packer u_write_packer (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .id_i       (id_i),
    .aw_valid_i (aw_valid_i),
    .aw_ready_o (aw_ready_o),
    .aw_id_i    (aw_id_i),
    .aw_addr_i  (aw_addr_i),
    .aw_len_i   (aw_len_i),
    .w_valid_i  (w_valid_i),
    .w_ready_o  (w_ready_o),
    .w_data_i   (w_data_i),
    .w_last_i   (w_last_i),
    .wr_flit    (wr_flit)
  );

  floo_read_packer u_read_packer (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .id_i       (id_i),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .ar_id_i    (ar_id_i),
    .ar_addr_i  (ar_addr_i),
    .ar_len_i   (ar_len_i),
    .rd_flit    (rd_flit)
  );

  floo_wormhole_arbiter u_wormhole_arbiter (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .wr_flit        (wr_flit),
    .rd_flit        (rd_flit),
    .floo_valid_o   (floo_valid_o),
    .floo_ready_i   (floo_ready_i),
    .floo_hdr_o     (floo_hdr_o),
    .floo_payload_o (floo_payload_o)
  );

endmodule

`default_nettype wire

// ==== hdl/floo_wormhole_arbiter.sv ====
////////////////////////////////////////////////////////////////////////////
// Merges the write and read flit streams onto one link. Round-robin while
// unlocked, then held on one input until a flit with last set has gone.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "floo_consts.svh"

module floo_wormhole_arbiter (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  flit_stream_if.dst                  wr_flit,
  flit_stream_if.dst                  rd_flit,
  output logic                        floo_valid_o,
  input  wire logic                   floo_ready_i,
  output floo_pkg::floo_hdr_t         floo_hdr_o,
  output logic [`FLOO_PAYLOAD_W-1:0]  floo_payload_o
);
  import floo_pkg::*;

  localparam int unsigned IDX_W = $clog2(`FLOO_ARB_N);
  typedef logic [IDX_W-1:0] idx_t;
  localparam idx_t WR_IDX = idx_t'(0);
  localparam idx_t RD_IDX = idx_t'(1);

  logic [`FLOO_ARB_N-1:0]     in_valid;
  floo_hdr_t                  in_hdr     [`FLOO_ARB_N];
  logic [`FLOO_PAYLOAD_W-1:0] in_payload [`FLOO_ARB_N];
  logic                       locked_q;
  idx_t                       sel_q;
  idx_t                       last_q;
  idx_t                       next_idx;
  idx_t                       sel;
  logic                       xfer;

  assign in_valid[WR_IDX]   = wr_flit.valid;
  assign in_valid[RD_IDX]   = rd_flit.valid;
  assign in_hdr[WR_IDX]     = wr_flit.hdr;
  assign in_hdr[RD_IDX]     = rd_flit.hdr;
  assign in_payload[WR_IDX] = wr_flit.payload;
  assign in_payload[RD_IDX] = rd_flit.payload;

  ////////////////////////////////////////////////////////////////////////////
  // Grant

  // Input after the last-served one, wraps for a power-of-two count
  assign next_idx = last_q + 1'b1;

  always_comb begin
    sel = next_idx;
    if (locked_q) begin
      sel = sel_q;
    end else if (!in_valid[next_idx] && in_valid[last_q]) begin
      sel = last_q;
    end
  end

  assign floo_valid_o   = in_valid[sel];
  assign floo_hdr_o     = in_hdr[sel];
  assign floo_payload_o = in_payload[sel];
  assign xfer           = floo_valid_o && floo_ready_i;

  assign wr_flit.ready = (sel == WR_IDX) && floo_ready_i;
  assign rd_flit.ready = (sel == RD_IDX) && floo_ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // Lock state

  // A stalled flit keeps its grant too, so the output stays stable
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      locked_q <= 1'b0;
      sel_q    <= WR_IDX;
      last_q   <= RD_IDX;
    end else if (floo_valid_o && !floo_ready_i) begin
      locked_q <= 1'b1;
      sel_q    <= sel;
    end else if (xfer) begin
      locked_q <= !floo_hdr_o.last;
      sel_q    <= sel;
      last_q   <= sel;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/floo_read_packer.sv ====
////////////////////////////////////////////////////////////////////////////
// Read request packer. AR goes through a one-entry cut and each read
// leaves as one single-flit packet routed by its address.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "floo_consts.svh"

module floo_read_packer (
  input  wire logic                      clk_i,
  input  wire logic                      rst_i,
  input  wire logic [`FLOO_ID_W-1:0]     id_i,
  // AR
  input  wire logic                      ar_valid_i,
  output logic                           ar_ready_o,
  input  wire logic [`FLOO_AXI_ID_W-1:0] ar_id_i,
  input  wire logic [`FLOO_ADDR_W-1:0]   ar_addr_i,
  input  wire logic [`FLOO_LEN_W-1:0]    ar_len_i,
  // Flits towards the arbiter
  flit_stream_if.src                     rd_flit
);
  import floo_pkg::*;

  logic                      ar_q_valid;
  logic [`FLOO_AXI_ID_W-1:0] ar_q_id;
  logic [`FLOO_ADDR_W-1:0]   ar_q_addr;
  logic [`FLOO_LEN_W-1:0]    ar_q_len;
  logic                      ar_flit_xfer;

  assign ar_flit_xfer = ar_q_valid && rd_flit.ready;
  assign ar_ready_o   = !ar_q_valid || ar_flit_xfer;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ar_q_valid <= 1'b0;
    end else if (ar_valid_i && ar_ready_o) begin
      ar_q_valid <= 1'b1;
    end else if (ar_flit_xfer) begin
      ar_q_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_valid_i && ar_ready_o) begin
      ar_q_id   <= ar_id_i;
      ar_q_addr <= ar_addr_i;
      ar_q_len  <= ar_len_i;
    end
  end

  // A read request is always a single-flit packet
  assign rd_flit.valid   = ar_q_valid;
  assign rd_flit.payload = {ar_q_id, ar_q_addr, ar_q_len};
  assign rd_flit.hdr     = '{
    dst_id: ar_q_addr[`FLOO_ID_ADDR_OFFSET +: `FLOO_ID_W],
    src_id: id_i,
    axi_ch: CH_AR,
    last:   1'b1
  };

endmodule

`default_nettype wire

// ==== hdl/floo_write_packer.sv ====
////////////////////////////////////////////////////////////////////////////
// Write request packer. AW goes through a one-entry cut and leaves as a
// single flit, then the W beats of that burst follow as flits routed to
// the destination latched when the AW flit was sent.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "floo_consts.svh"

module floo_write_packer (
  input  wire logic                      clk_i,
  input  wire logic                      rst_i,
  input  wire logic [`FLOO_ID_W-1:0]     id_i,
  // AW
  input  wire logic                      aw_valid_i,
  output logic                           aw_ready_o,
  input  wire logic [`FLOO_AXI_ID_W-1:0] aw_id_i,
  input  wire logic [`FLOO_ADDR_W-1:0]   aw_addr_i,
  input  wire logic [`FLOO_LEN_W-1:0]    aw_len_i,
  // W
  input  wire logic                      w_valid_i,
  output logic                           w_ready_o,
  input  wire logic [`FLOO_DATA_W-1:0]   w_data_i,
  input  wire logic                      w_last_i,
  // Flits towards the arbiter
  flit_stream_if.src                     wr_flit
);
  import floo_pkg::*;

  floo_wr_sel_e              sel_q;
  logic                      aw_q_valid;
  logic [`FLOO_AXI_ID_W-1:0] aw_q_id;
  logic [`FLOO_ADDR_W-1:0]   aw_q_addr;
  logic [`FLOO_LEN_W-1:0]    aw_q_len;
  logic [`FLOO_ID_W-1:0]     aw_dst;
  logic [`FLOO_ID_W-1:0]     w_dst_q;
  logic                      aw_flit_xfer;
  logic                      w_flit_xfer;
  floo_hdr_t                 flit_hdr;

  ////////////////////////////////////////////////////////////////////////////
  // AW cut

  assign aw_flit_xfer = (sel_q == SEL_AW) && aw_q_valid && wr_flit.ready;
  assign w_flit_xfer  = (sel_q == SEL_W) && w_valid_i && wr_flit.ready;

  // Refill in the same cycle the held AW leaves
  assign aw_ready_o = !aw_q_valid || aw_flit_xfer;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      aw_q_valid <= 1'b0;
    end else if (aw_valid_i && aw_ready_o) begin
      aw_q_valid <= 1'b1;
    end else if (aw_flit_xfer) begin
      aw_q_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_valid_i && aw_ready_o) begin
      aw_q_id   <= aw_id_i;
      aw_q_addr <= aw_addr_i;
      aw_q_len  <= aw_len_i;
    end
    if (aw_flit_xfer) begin
      w_dst_q <= aw_dst;
    end
  end

  assign aw_dst = aw_q_addr[`FLOO_ID_ADDR_OFFSET +: `FLOO_ID_W];

  ////////////////////////////////////////////////////////////////////////////
  // AW/W sequencer

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sel_q <= SEL_AW;
    end else if (aw_flit_xfer) begin
      sel_q <= SEL_W;
    end else if (w_flit_xfer && w_last_i) begin
      sel_q <= SEL_AW;
    end
  end

  // W is accepted only once its AW flit has gone out
  assign w_ready_o = (sel_q == SEL_W) && wr_flit.ready;

  ////////////////////////////////////////////////////////////////////////////
  // Flit packing

  always_comb begin
    flit_hdr.src_id = id_i;
    if (sel_q == SEL_AW) begin
      flit_hdr.dst_id = aw_dst;
      flit_hdr.axi_ch = CH_AW;
      flit_hdr.last   = 1'b1;
      wr_flit.valid   = aw_q_valid;
      wr_flit.payload = {aw_q_id, aw_q_addr, aw_q_len};
    end else begin
      flit_hdr.dst_id = w_dst_q;
      flit_hdr.axi_ch = CH_W;
      flit_hdr.last   = w_last_i;
      wr_flit.valid   = w_valid_i;
      wr_flit.payload = {{(`FLOO_PAYLOAD_W - `FLOO_DATA_W){1'b0}}, w_data_i};
    end
  end

  assign wr_flit.hdr = flit_hdr;

endmodule

`default_nettype wire

// ==== hdl/flit_stream_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Valid/ready flit stream between a packer and the wormhole arbiter.
// The packer connects to src, the arbiter to dst.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "floo_consts.svh"

interface flit_stream_if;
  import floo_pkg::*;

  logic                       valid;
  logic                       ready;
  floo_hdr_t                  hdr;
  logic [`FLOO_PAYLOAD_W-1:0] payload;

  // Producer side
  modport src (
    output valid,
    output hdr,
    output payload,
    input  ready
  );

  // Consumer side
  modport dst (
    input  valid,
    input  hdr,
    input  payload,
    output ready
  );

endinterface

`default_nettype wire

// ==== hdl/floo_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared types of the request chimney: the channel kind carried in each
// flit header, the AW/W sequencer state and the header layout itself.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "floo_consts.svh"

package floo_pkg;

  // Channel kind of a request flit
  typedef enum logic [1:0] {
    CH_AW = 2'd0,
    CH_W  = 2'd1,
    CH_AR = 2'd2
  } floo_axi_ch_e;

  // Write sequencer, AW flit first and then its W beats
  typedef enum logic {
    SEL_AW = 1'b0,
    SEL_W  = 1'b1
  } floo_wr_sel_e;

  // Flit header, 11 bits
  typedef struct packed {
    logic [`FLOO_ID_W-1:0] dst_id;
    logic [`FLOO_ID_W-1:0] src_id;
    floo_axi_ch_e          axi_ch;
    logic                  last;
  } floo_hdr_t;

endpackage

`default_nettype wire

// ==== hdl/floo_consts.svh ====
////////////////////////////////////////////////////////////////////////////
// Width and routing constants for the request chimney.
// Include this wherever a field width or the ID address offset is needed.
////////////////////////////////////////////////////////////////////////////

`ifndef FLOO_CONSTS_SVH
`define FLOO_CONSTS_SVH

// Field widths
`define FLOO_ID_W           4
`define FLOO_AXI_ID_W       4
`define FLOO_ADDR_W         32
`define FLOO_LEN_W          8
`define FLOO_DATA_W         32

// AXI ID, address and length, packed from the high bits
`define FLOO_PAYLOAD_W      44

// Destination ID sits in the address from this bit upwards
`define FLOO_ID_ADDR_OFFSET 8

// Number of flit streams merged by the wormhole arbiter
`define FLOO_ARB_N          2

`endif
